/* design/sram_test_pkg.sv */
package sram_test_pkg;

   ////////////////////////////////////////////////////////////
   // widths
   ////////////////////////////////////////////////////////////
   localparam int SRAM_ADDR_WIDTH = 10;
   localparam int SRAM_DATA_WIDTH = 36;
   localparam int ERR_CNT_WIDTH   = 16;

   typedef logic [SRAM_ADDR_WIDTH-1:0] sram_addr_t;
   typedef logic [SRAM_DATA_WIDTH-1:0] sram_data_t;
   typedef logic [ERR_CNT_WIDTH-1:0]   err_cnt_t;

   // host command opcodes
   typedef enum logic {
      CMD_RUN   = 1'b0,
      CMD_CLEAR = 1'b1
   } cmd_op_t;

   // command decoder states
   typedef enum logic [1:0] {
      DEC_IDLE     = 2'd0,
      DEC_RUN_WAIT = 2'd1,
      DEC_ACK_HOLD = 2'd2,
      DEC_REQ_LOW  = 2'd3
   } decode_state_t;

   // pattern engine states
   typedef enum logic [1:0] {
      PAT_IDLE  = 2'd0,
      PAT_WRITE = 2'd1,
      PAT_READ  = 2'd2
   } pat_state_t;

   // 36-bit lfsr step; all-zero state feeds a one back in
   function automatic sram_data_t next_pattern(input sram_data_t prev);
      logic feed_in;
      feed_in = (prev[35] ^ prev[24]) ^ ~(|prev[34:0]);
      return {prev[34:0], feed_in};
   endfunction

endpackage

/* design/sram_test_cmd_decode.sv */
`timescale 1ns/10ps

module sram_test_cmd_decode (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       cmd_req,
   input  sram_test_pkg::cmd_op_t     cmd_op,
   input  sram_test_pkg::sram_data_t  cmd_seed,
   input  logic                       done,
   output logic                       cmd_ack,
   output logic                       busy,
   output logic                       start,
   output sram_test_pkg::sram_data_t  seed,
   output logic                       clear_req
);
   import sram_test_pkg::*;

   decode_state_t state;

   // busy from acceptance through the whole handshake
   assign busy = (state != DEC_IDLE);

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= DEC_IDLE;
         cmd_ack   <= 1'b0;
         start     <= 1'b0;
         clear_req <= 1'b0;
      end else begin
         start     <= 1'b0;
         clear_req <= 1'b0;
         case (state)
            DEC_IDLE:
               if (cmd_req && !cmd_ack) begin
                  if (cmd_op == CMD_RUN) begin
                     start <= 1'b1;
                     state <= DEC_RUN_WAIT;
                  end else begin
                     clear_req <= 1'b1;
                     state     <= DEC_ACK_HOLD;
                  end
               end
            DEC_RUN_WAIT:
               if (done) begin
                  state <= DEC_ACK_HOLD;
               end
            DEC_ACK_HOLD: begin
               cmd_ack <= 1'b1;
               // release only once the host has seen ack
               if (cmd_ack && !cmd_req) begin
                  state <= DEC_REQ_LOW;
               end
            end
            DEC_REQ_LOW: begin
               cmd_ack <= 1'b0;
               state   <= DEC_IDLE;
            end
            default: state <= DEC_IDLE;
         endcase
      end
   end

   // seed held for the whole run
   always_ff @(posedge clk) begin
      if (state == DEC_IDLE && cmd_req && !cmd_ack && cmd_op == CMD_RUN) begin
         seed <= cmd_seed;
      end
   end

endmodule

/* design/sram_test_rand_pat.sv */
`timescale 1ns/10ps

module sram_test_rand_pat (
   input  logic                       clk,
   input  logic                       reset,
   // from decode
   input  logic                       start,
   input  sram_test_pkg::sram_data_t  seed,
   // controller side
   input  logic                       ack,
   input  sram_test_pkg::sram_data_t  rd_data,
   output logic                       req,
   output logic                       rd,
   output sram_test_pkg::sram_addr_t  addr,
   output sram_test_pkg::sram_data_t  wr_data,
   // back to decode
   output logic                       done,
   // error log
   output logic                       log_vld,
   output sram_test_pkg::sram_addr_t  log_addr,
   output sram_test_pkg::sram_data_t  log_exp_data,
   output sram_test_pkg::sram_data_t  log_rd_data
);
   import sram_test_pkg::*;

   pat_state_t state;

   // pattern for the word after the current one in write,
   // expected word for the current address in read
   sram_data_t pat;

   logic last_addr;

   assign last_addr = &addr;

   ////////////////////////////////////////////////////////////
   // control state
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         state   <= PAT_IDLE;
         req     <= 1'b0;
         rd      <= 1'b0;
         done    <= 1'b0;
         log_vld <= 1'b0;
      end else begin
         done    <= 1'b0;
         log_vld <= 1'b0;
         case (state)
            PAT_IDLE:
               if (start) begin
                  req   <= 1'b1;
                  rd    <= 1'b0;
                  state <= PAT_WRITE;
               end
            PAT_WRITE:
               // wrap back to 0 ends the write pass
               if (ack && last_addr) begin
                  rd    <= 1'b1;
                  state <= PAT_READ;
               end
            PAT_READ:
               if (ack) begin
                  if (rd_data != pat) begin
                     log_vld <= 1'b1;
                  end
                  if (last_addr) begin
                     req   <= 1'b0;
                     done  <= 1'b1;
                     state <= PAT_IDLE;
                  end
               end
            default: state <= PAT_IDLE;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // address and pattern datapath
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      case (state)
         PAT_IDLE:
            if (start) begin
               addr    <= '0;
               wr_data <= seed;
               pat     <= next_pattern(seed);
            end
         PAT_WRITE:
            if (ack) begin
               addr    <= addr + 1'b1;
               wr_data <= pat;
               pat     <= next_pattern(pat);
               // read pass regenerates from the seed
               if (last_addr) begin
                  pat <= seed;
               end
            end
         PAT_READ:
            if (ack) begin
               addr <= addr + 1'b1;
               pat  <= next_pattern(pat);
            end
         default: ;
      endcase
   end

   // mismatch details travel with log_vld
   always_ff @(posedge clk) begin
      if (state == PAT_READ && ack && rd_data != pat) begin
         log_addr     <= addr;
         log_exp_data <= pat;
         log_rd_data  <= rd_data;
      end
   end

endmodule

/* design/sram_ctrl.sv */
`timescale 1ns/10ps

module sram_ctrl (
   input  logic                       clk,
   input  logic                       reset,
   // tester side
   input  logic                       req,
   input  logic                       rd,
   input  sram_test_pkg::sram_addr_t  addr,
   input  sram_test_pkg::sram_data_t  wr_data,
   output logic                       ack,
   output sram_test_pkg::sram_data_t  rd_data,
   // sram pins
   output logic                       sram_en,
   output logic                       sram_we,
   output sram_test_pkg::sram_addr_t  sram_addr,
   output sram_test_pkg::sram_data_t  sram_wr_data,
   input  sram_test_pkg::sram_data_t  sram_rd_data
);

   logic       pending;
   logic       issue;
   logic [1:0] vld;

   // one access in flight, next one after ack
   assign issue = req && !pending;

   always_ff @(posedge clk) begin
      if (reset) begin
         pending <= 1'b0;
         vld     <= 2'b00;
         ack     <= 1'b0;
         sram_en <= 1'b0;
         sram_we <= 1'b0;
      end else begin
         sram_en <= issue;
         sram_we <= issue && !rd;
         // enable cycle, then read data cycle
         vld     <= {vld[0], issue};
         ack     <= vld[1];
         if (issue) begin
            pending <= 1'b1;
         end else if (ack) begin
            pending <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (issue) begin
         sram_addr    <= addr;
         sram_wr_data <= wr_data;
      end
      if (vld[1]) begin
         rd_data <= sram_rd_data;
      end
   end

endmodule

/* design/sram_test_result.sv */
`timescale 1ns/10ps

module sram_test_result (
   input  logic                       clk,
   input  logic                       reset,
   input  logic                       run_start,
   input  logic                       clear_req,
   input  logic                       log_vld,
   input  sram_test_pkg::sram_addr_t  log_addr,
   input  sram_test_pkg::sram_data_t  log_exp_data,
   input  sram_test_pkg::sram_data_t  log_rd_data,
   output logic                       fail,
   output sram_test_pkg::err_cnt_t    err_count,
   output sram_test_pkg::sram_addr_t  first_addr,
   output sram_test_pkg::sram_data_t  first_exp,
   output sram_test_pkg::sram_data_t  first_rd
);

   // set once the first error of this run is held
   logic first_held;

   ////////////////////////////////////////////////////////////
   // status and counter
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         fail       <= 1'b0;
         err_count  <= '0;
         first_held <= 1'b0;
      end else if (clear_req) begin
         // count and log only; fail is kept
         err_count  <= '0;
         first_held <= 1'b0;
      end else begin
         if (run_start) begin
            fail       <= 1'b0;
            first_held <= 1'b0;
         end
         if (log_vld) begin
            fail       <= 1'b1;
            first_held <= 1'b1;
            if (err_count != '1) begin
               err_count <= err_count + 1'b1;
            end
         end
      end
   end

   // first failing word of the run
   always_ff @(posedge clk) begin
      if (clear_req) begin
         first_addr <= '0;
         first_exp  <= '0;
         first_rd   <= '0;
      end else if (log_vld && (!first_held || run_start)) begin
         first_addr <= log_addr;
         first_exp  <= log_exp_data;
         first_rd   <= log_rd_data;
      end
   end

endmodule

/* design/sram_test_top.sv */
`timescale 1ns/10ps

module sram_test_top (
   input  logic                       clk,
   input  logic                       reset,
   // host command handshake
   input  logic                       cmd_req,
   input  sram_test_pkg::cmd_op_t     cmd_op,
   input  sram_test_pkg::sram_data_t  cmd_seed,
   output logic                       cmd_ack,
   output logic                       busy,
   // status
   output logic                       fail,
   output sram_test_pkg::err_cnt_t    err_count,
   output sram_test_pkg::sram_addr_t  first_addr,
   output sram_test_pkg::sram_data_t  first_exp,
   output sram_test_pkg::sram_data_t  first_rd,
   // sram pins
   output logic                       sram_en,
   output logic                       sram_we,
   output sram_test_pkg::sram_addr_t  sram_addr,
   output sram_test_pkg::sram_data_t  sram_wr_data,
   input  sram_test_pkg::sram_data_t  sram_rd_data
);
   import sram_test_pkg::*;

   logic       start;
   logic       done;
   logic       clear_req;
   sram_data_t seed;

   logic       req;
   logic       rd;
   logic       ack;
   sram_addr_t addr;
   sram_data_t wr_data;
   sram_data_t rd_data;

   logic       log_vld;
   sram_addr_t log_addr;
   sram_data_t log_exp_data;
   sram_data_t log_rd_data;

   sram_test_cmd_decode u_decode (
      .clk       (clk),
      .reset     (reset),
      .cmd_req   (cmd_req),
      .cmd_op    (cmd_op),
      .cmd_seed  (cmd_seed),
      .done      (done),
      .cmd_ack   (cmd_ack),
      .busy      (busy),
      .start     (start),
      .seed      (seed),
      .clear_req (clear_req)
   );

   sram_test_rand_pat u_rand_pat (
      .clk          (clk),
      .reset        (reset),
      .start        (start),
      .seed         (seed),
      .ack          (ack),
      .rd_data      (rd_data),
      .req          (req),
      .rd           (rd),
      .addr         (addr),
      .wr_data      (wr_data),
      .done         (done),
      .log_vld      (log_vld),
      .log_addr     (log_addr),
      .log_exp_data (log_exp_data),
      .log_rd_data  (log_rd_data)
   );

   sram_ctrl u_sram_ctrl (
      .clk          (clk),
      .reset        (reset),
      .req          (req),
      .rd           (rd),
      .addr         (addr),
      .wr_data      (wr_data),
      .ack          (ack),
      .rd_data      (rd_data),
      .sram_en      (sram_en),
      .sram_we      (sram_we),
      .sram_addr    (sram_addr),
      .sram_wr_data (sram_wr_data),
      .sram_rd_data (sram_rd_data)
   );

   // run_start shares the start pulse
   sram_test_result u_result (
      .clk          (clk),
      .reset        (reset),
      .run_start    (start),
      .clear_req    (clear_req),
      .log_vld      (log_vld),
      .log_addr     (log_addr),
      .log_exp_data (log_exp_data),
      .log_rd_data  (log_rd_data),
      .fail         (fail),
      .err_count    (err_count),
      .first_addr   (first_addr),
      .first_exp    (first_exp),
      .first_rd     (first_rd)
   );

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen #(
   parameter int PERIOD = 40
) (
   output logic clk
);

   initial clk = 1'b0;

   always #(PERIOD / 2) clk = ~clk;

endmodule

/* bench/sram_model.sv */
`timescale 1ns/10ps

module sram_model (
   input  logic                       clk,
   input  logic                       en,
   input  logic                       we,
   input  sram_test_pkg::sram_addr_t  addr,
   input  sram_test_pkg::sram_data_t  wr_data,
   output sram_test_pkg::sram_data_t  rd_data,
   // one stuck bit at one address, seen on reads
   input  logic                       fault_en,
   input  sram_test_pkg::sram_addr_t  fault_addr,
   input  logic [5:0]                 fault_bit,
   input  logic                       fault_val
);
   import sram_test_pkg::*;

   localparam int NUM_WORDS = 2 ** SRAM_ADDR_WIDTH;

   sram_data_t mem [0:NUM_WORDS-1];
   sram_data_t word;

   always_comb begin
      word = mem[addr];
      if (fault_en && addr == fault_addr) begin
         word[fault_bit] = fault_val;
      end
   end

   // read data one cycle after the enable cycle
   always @(posedge clk) begin
      if (en && we) begin
         mem[addr] <= wr_data;
      end else if (en) begin
         rd_data <= word;
      end
   end

endmodule

/* bench/sram_test_tb.sv */
`timescale 1ns/10ps

module sram_test_tb;
   import sram_test_pkg::*;

   localparam int NUM_WORDS  = 2 ** SRAM_ADDR_WIDTH;
   localparam int NUM_RUNS   = 5;
   localparam int MAX_CYCLES = NUM_RUNS * 10 * NUM_WORDS + 2000;

   logic       clk;
   logic       reset;
   logic       cmd_req;
   cmd_op_t    cmd_op;
   sram_data_t cmd_seed;
   logic       cmd_ack;
   logic       busy;
   logic       fail;
   err_cnt_t   err_count;
   sram_addr_t first_addr;
   sram_data_t first_exp;
   sram_data_t first_rd;
   logic       sram_en;
   logic       sram_we;
   sram_addr_t sram_addr;
   sram_data_t sram_wr_data;
   sram_data_t sram_rd_data;
   logic       fault_en;
   sram_addr_t fault_addr;
   logic [5:0] fault_bit;
   logic       fault_val;

   int          errors;
   int          errors_at_open;
   int          tests_passed;
   int          tests_failed;
   int          cycle_count;

   clk_gen #(.PERIOD(40)) u_clk_gen (.clk(clk));

   sram_test_top u_sram_test_top (
      .clk          (clk),
      .reset        (reset),
      .cmd_req      (cmd_req),
      .cmd_op       (cmd_op),
      .cmd_seed     (cmd_seed),
      .cmd_ack      (cmd_ack),
      .busy         (busy),
      .fail         (fail),
      .err_count    (err_count),
      .first_addr   (first_addr),
      .first_exp    (first_exp),
      .first_rd     (first_rd),
      .sram_en      (sram_en),
      .sram_we      (sram_we),
      .sram_addr    (sram_addr),
      .sram_wr_data (sram_wr_data),
      .sram_rd_data (sram_rd_data)
   );

   sram_model u_sram_model (
      .clk        (clk),
      .en         (sram_en),
      .we         (sram_we),
      .addr       (sram_addr),
      .wr_data    (sram_wr_data),
      .rd_data    (sram_rd_data),
      .fault_en   (fault_en),
      .fault_addr (fault_addr),
      .fault_bit  (fault_bit),
      .fault_val  (fault_val)
   );

   ////////////////////////////////////////////////////////////
   // reference model
   ////////////////////////////////////////////////////////////

   // taps 35 and 24, new bit into bit 0, inverted when 34:0 is zero
   function automatic sram_data_t lfsr_step(input sram_data_t cur);
      logic fb;
      fb = cur[35] ^ cur[24];
      if (cur[34:0] == 35'd0) begin
         fb = ~fb;
      end
      return {cur[34:0], fb};
   endfunction

   // word written at address a for a given seed
   function automatic sram_data_t pattern_at(input sram_data_t seed, input sram_addr_t a);
      sram_data_t p;
      p = seed;
      for (int i = 0; i < int'(a); i++) begin
         p = lfsr_step(p);
      end
      return p;
   endfunction

   function automatic sram_data_t random_word();
      logic [63:0] r;
      r = {$urandom, $urandom};
      return r[SRAM_DATA_WIDTH-1:0];
   endfunction

   ////////////////////////////////////////////////////////////
   // compare tasks
   ////////////////////////////////////////////////////////////
   task automatic check_count(input string name, input err_cnt_t exp, input err_cnt_t act);
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s: expected %0d, actual %0d", name, exp, act);
      end
   endtask

   task automatic check_addr(input string name, input sram_addr_t exp, input sram_addr_t act);
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s: expected 0x%03h, actual 0x%03h", name, exp, act);
      end
   endtask

   task automatic check_data(input string name, input sram_data_t exp, input sram_data_t act);
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s: expected 0x%09h, actual 0x%09h", name, exp, act);
      end
   endtask

   task automatic check_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         errors++;
         $display("MISMATCH %s: expected %b, actual %b", name, exp, act);
      end
   endtask

   task automatic open_test();
      errors_at_open = errors;
   endtask

   task automatic close_test(input string name);
      if (errors == errors_at_open) begin
         tests_passed++;
         $display("test %s: pass", name);
      end else begin
         tests_failed++;
         $display("test %s: fail, %0d errors", name, errors - errors_at_open);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // host side
   ////////////////////////////////////////////////////////////

   // four-phase command with ack held for hold_cycles before req drops
   task automatic issue_command(input string name, input cmd_op_t op,
                                input sram_data_t seed, input int hold_cycles);
      int waited;
      @(posedge clk);
      #2;
      cmd_op   = op;
      cmd_seed = seed;
      cmd_req  = 1'b1;
      waited   = 0;
      @(negedge clk);
      while (!cmd_ack) begin
         // first sample comes before the accepting edge
         if (waited > 0) begin
            check_flag({name, " busy"}, 1'b1, busy);
         end
         waited++;
         @(negedge clk);
      end
      check_flag({name, " busy at ack"}, 1'b1, busy);
      for (int i = 0; i < hold_cycles; i++) begin
         @(negedge clk);
         check_flag({name, " ack held"}, 1'b1, cmd_ack);
      end
      @(posedge clk);
      #2;
      cmd_req = 1'b0;
      repeat (2) @(posedge clk);
      #2;
      check_flag({name, " ack release"}, 1'b0, cmd_ack);
      check_flag({name, " busy release"}, 1'b0, busy);
   endtask

   task automatic verify_memory(input string name, input sram_data_t seed);
      sram_data_t p;
      p = seed;
      for (int a = 0; a < NUM_WORDS; a++) begin
         if (u_sram_model.mem[a] !== p) begin
            check_data($sformatf("%s word %0d", name, a), p, u_sram_model.mem[a]);
            break;
         end
         p = lfsr_step(p);
      end
   endtask

   // one run with a stuck bit and the expected count step in added
   task automatic fault_run(input string name, output int added);
      sram_data_t  seed;
      sram_data_t  exp_word;
      sram_data_t  bad_word;
      sram_addr_t  f_addr;
      logic [31:0] rnd;
      int          f_bit;
      logic        f_val;
      err_cnt_t    count_before;
      seed     = random_word();
      rnd      = $urandom;
      f_addr   = rnd[SRAM_ADDR_WIDTH-1:0];
      f_bit    = $urandom % SRAM_DATA_WIDTH;
      rnd      = $urandom;
      f_val    = rnd[0];
      exp_word = pattern_at(seed, f_addr);
      bad_word = exp_word;
      bad_word[f_bit] = f_val;
      added    = (bad_word != exp_word) ? 1 : 0;
      count_before = err_count;
      @(posedge clk);
      #2;
      fault_en   = 1'b1;
      fault_addr = f_addr;
      fault_bit  = f_bit[5:0];
      fault_val  = f_val;
      issue_command(name, CMD_RUN, seed, 1);
      fault_en = 1'b0;
      check_flag({name, " fail"}, added == 1, fail);
      check_count({name, " count"}, count_before + err_cnt_t'(added), err_count);
      if (added == 1) begin
         check_addr({name, " first addr"}, f_addr, first_addr);
         check_data({name, " first exp"}, exp_word, first_exp);
         check_data({name, " first rd"}, bad_word, first_rd);
      end
   endtask

   // run limit
   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= MAX_CYCLES) begin
         $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
         $display("TEST FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      sram_data_t seed;
      err_cnt_t   count_before;
      logic       fail_before;
      int         add1;
      int         add2;
      void'($urandom(80));
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      cycle_count  = 0;
      reset      = 1'b1;
      cmd_req    = 1'b0;
      cmd_op     = CMD_RUN;
      cmd_seed   = '0;
      fault_en   = 1'b0;
      fault_addr = '0;
      fault_bit  = '0;
      fault_val  = 1'b0;
      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;

      open_test();
      @(negedge clk);
      check_flag("reset cmd_ack", 1'b0, cmd_ack);
      check_flag("reset busy", 1'b0, busy);
      check_flag("reset sram_en", 1'b0, sram_en);
      check_flag("reset sram_we", 1'b0, sram_we);
      check_flag("reset fail", 1'b0, fail);
      check_count("reset err_count", '0, err_count);
      close_test("reset");

      open_test();
      seed = random_word();
      count_before = err_count;
      issue_command("clean", CMD_RUN, seed, 1);
      check_flag("clean fail", 1'b0, fail);
      check_count("clean count", count_before, err_count);
      verify_memory("clean memory", seed);
      close_test("clean");

      open_test();
      fault_run("fault", add1);
      close_test("fault");

      open_test();
      count_before = err_count;
      fault_run("accum 1", add1);
      fault_run("accum 2", add2);
      check_count("accum total", count_before + err_cnt_t'(add1 + add2), err_count);
      fail_before = fail;
      issue_command("clear", CMD_CLEAR, '0, 1);
      check_count("clear count", '0, err_count);
      check_flag("clear fail", fail_before, fail);
      close_test("accumulate");

      open_test();
      issue_command("handshake", CMD_RUN, random_word(), 6);
      check_flag("handshake fail", 1'b0, fail);
      close_test("handshake");

      $display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("TEST PASSED");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

/* list.f */
design/sram_test_pkg.sv
design/sram_test_cmd_decode.sv
design/sram_test_rand_pat.sv
design/sram_ctrl.sv
design/sram_test_result.sv
design/sram_test_top.sv
bench/clk_gen.sv
bench/sram_model.sv
bench/sram_test_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= sram_test_tb
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
